/* verilog.f */
hdl/panelPkg.sv
hdl/memLane.sv
hdl/multiLaneMem.sv
hdl/frameLoader.sv
hdl/scanController.sv
hdl/ledPanelTop.sv
tb/tbClock.sv
tb/tbChecker.sv
tb/tbTop.sv

/* tb/tbTop.sv */
module tbTop;
    timeunit 1ns;
    timeprecision 100ps;
    import panelPkg::*;

    localparam int unsigned randSeed = 32'h251b5b81;
    // one row takes 65 slots of 4 cycles plus blank and latch
    localparam int latchTimeout = 400;
    localparam int levelTimeout = 64;
    localparam int resetTimeout = 20;
    localparam int extraBytes = 24;

    logic ClockB;
    logic rstN;
    logic frameStart;
    logic byteValid;
    laneWordT byteData;
    logic scanEn;
    logic frameLoaded;
    logic r1;
    logic g1;
    logic b1;
    logic r2;
    logic g2;
    logic b2;
    logic panelClk;
    logic latch;
    logic oeN;
    logic [rowBits-1:0] rowAddr;
    // compare colours at each latch
    logic checkOn;
    // scan has never been enabled
    logic scanIdle;
    int pixelErrors;
    int protoErrors;
    int partLen;

    tbClock clkGen (
        .ClockB (ClockB),
        .rstN   (rstN)
    );

    ledPanelTop dut (
        .ClockB      (ClockB),
        .rstN        (rstN),
        .frameStart  (frameStart),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .scanEn      (scanEn),
        .frameLoaded (frameLoaded),
        .r1          (r1),
        .g1          (g1),
        .b1          (b1),
        .r2          (r2),
        .g2          (g2),
        .b2          (b2),
        .panelClk    (panelClk),
        .latch       (latch),
        .oeN         (oeN),
        .rowAddr     (rowAddr)
    );

    tbChecker chk (
        .ClockB      (ClockB),
        .rstN        (rstN),
        .frameStart  (frameStart),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .frameLoaded (frameLoaded),
        .r1          (r1),
        .g1          (g1),
        .b1          (b1),
        .r2          (r2),
        .g2          (g2),
        .b2          (b2),
        .panelClk    (panelClk),
        .latch       (latch),
        .oeN         (oeN),
        .rowAddr     (rowAddr),
        .checkOn     (checkOn),
        .scanIdle    (scanIdle),
        .pixelErrors (pixelErrors),
        .protoErrors (protoErrors)
    );

    task automatic finishRun(input string reason);
        if (reason != "") begin
            $display("%s", reason);
        end
        $display("summary: %0d pixel errors, %0d protocol errors, %0d timeouts",
                 pixelErrors, protoErrors, (reason != "") ? 1 : 0);
        if (reason == "" && pixelErrors == 0 && protoErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic awaitReset();
        int n;
        n = 0;
        while (rstN !== 1'b1 && n < resetTimeout) begin
            @(negedge ClockB);
            n++;
        end
        if (rstN !== 1'b1) begin
            finishRun("timeout: reset was never released");
        end
    endtask

    // random bytes with up to maxGap idle cycles before each one
    task automatic sendBytes(input int count, input int maxGap, input bit withStart);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = (maxGap > 0) ? int'($urandom % (maxGap + 1)) : 0;
            repeat (gap) begin
                @(negedge ClockB);
                byteValid = 1'b0;
                frameStart = 1'b0;
            end
            @(negedge ClockB);
            byteValid = 1'b1;
            byteData = laneWordT'($urandom);
            frameStart = withStart && (i == 0);
        end
        @(negedge ClockB);
        byteValid = 1'b0;
        frameStart = 1'b0;
    endtask

    task automatic pulseFrameStart();
        @(negedge ClockB);
        frameStart = 1'b1;
        @(negedge ClockB);
        frameStart = 1'b0;
    endtask

    task automatic awaitLoaded(input logic level);
        int n;
        n = 0;
        while (frameLoaded !== level && n < levelTimeout) begin
            @(negedge ClockB);
            n++;
        end
        if (frameLoaded !== level) begin
            finishRun($sformatf("timeout: frameLoaded never went to %b", level));
        end
    endtask

    task automatic countLatches(input int count);
        int n;
        int got;
        n = 0;
        got = 0;
        while (got < count && n < count * latchTimeout) begin
            @(negedge ClockB);
            if (latch) begin
                got++;
            end
            n++;
        end
        if (got < count) begin
            finishRun($sformatf("timeout: only %0d of %0d latches seen", got, count));
        end else begin
            // the row of the last latch is compared on the next rising edge
            @(negedge ClockB);
        end
    endtask

    // stops on the negedge right after row 0 is latched
    task automatic seekRowZero();
        int n;
        bit found;
        n = 0;
        found = 1'b0;
        while (!found && n < halfHeight * latchTimeout) begin
            @(negedge ClockB);
            found = latch && (rowAddr == '0);
            n++;
        end
        if (!found) begin
            finishRun("timeout: no latch of row 0 seen");
        end
    endtask

    initial begin
        frameStart = 1'b0;
        byteValid = 1'b0;
        byteData = '0;
        scanEn = 1'b0;
        checkOn = 1'b0;
        scanIdle = 1'b1;
        void'($urandom(randSeed));
        // reset values are checked by the checker on the first edge
        awaitReset();

        // first frame back to back with the first byte riding on frameStart
        sendBytes(frameBytes, 0, 1'b1);
        awaitLoaded(1'b1);

        // two full scans of a settled frame
        @(negedge ClockB);
        scanIdle = 1'b0;
        scanEn = 1'b1;
        checkOn = 1'b1;
        countLatches(2 * halfHeight);

        // second frame with gaps and trailing bytes while the display may tear
        checkOn = 1'b0;
        sendBytes(frameBytes, 3, 1'b1);
        sendBytes(extraBytes, 2, 1'b0);
        awaitLoaded(1'b1);
        seekRowZero();
        checkOn = 1'b1;
        countLatches(halfHeight);

        // abandon a load part way and restart from address 0
        checkOn = 1'b0;
        partLen = 100 + int'($urandom % 900);
        sendBytes(partLen, 1, 1'b1);
        awaitLoaded(1'b0);
        pulseFrameStart();
        sendBytes(frameBytes, 2, 1'b0);
        awaitLoaded(1'b1);
        seekRowZero();
        checkOn = 1'b1;
        countLatches(halfHeight);

        finishRun("");
    end

endmodule

/* tb/tbChecker.sv */
module tbChecker (
    input  logic                         ClockB,
    input  logic                         rstN,
    input  logic                         frameStart,
    input  logic                         byteValid,
    input  panelPkg::laneWordT           byteData,
    input  logic                         frameLoaded,
    input  logic                         r1,
    input  logic                         g1,
    input  logic                         b1,
    input  logic                         r2,
    input  logic                         g2,
    input  logic                         b2,
    input  logic                         panelClk,
    input  logic                         latch,
    input  logic                         oeN,
    input  logic [panelPkg::rowBits-1:0] rowAddr,
    input  logic                         checkOn,
    input  logic                         scanIdle,
    output int                           pixelErrors,
    output int                           protoErrors
);
    timeunit 1ns;
    timeprecision 100ps;
    import panelPkg::*;

    // host bytes in raster order, as the loader should have stored them
    logic [7:0] model [frameBytes];
    int nextAddr;
    // full after the previous edge and the one before it
    bit full;
    bit fullPrev;
    // six colour bits per column of the row being shifted
    logic [5:0] cols [panelWidth];
    int pulseCnt;
    logic clkPrev;
    logic [rowBits-1:0] shownRow;
    logic [rowBits-1:0] expRow;
    // was reset seen at the previous edge
    bit rstQ = 1'b1;

    initial begin
        pixelErrors = 0;
        protoErrors = 0;
    end

    task automatic reportProtocol(input string msg);
        protoErrors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // top half shows row, bottom half shows row + 16
    task automatic compareRow(input int row);
        int topBase;
        int botBase;
        logic [5:0] expBits;
        for (int c = 0; c < panelWidth; c++) begin
            // byte address is {half, row, column, byte select}
            topBase = (row * panelWidth + c) * bytesPerPixel;
            botBase = topBase + halfHeight * panelWidth * bytesPerPixel;
            // R from high bit 7, G from high bit 2, B from low bit 4
            expBits = {model[topBase][7], model[topBase][2], model[topBase + 1][4],
                       model[botBase][7], model[botBase][2], model[botBase + 1][4]};
            if (cols[c] !== expBits) begin
                pixelErrors++;
                $display("CHECK FAILED at %0t: row %0d col %0d expected %b got %b",
                         $time, row, c, expBits, cols[c]);
            end
        end
    endtask

    always @(posedge ClockB) begin
        if (!rstN) begin
            nextAddr = 0;
            full = 1'b0;
            fullPrev = 1'b0;
            pulseCnt = 0;
            clkPrev = 1'b0;
            shownRow = '0;
        end else begin
            // first edge out of reset sees the reset values
            if (!rstQ) begin
                if (oeN !== 1'b1 || latch !== 1'b0 || panelClk !== 1'b0) begin
                    reportProtocol("panel outputs not idle after reset");
                end
                if (frameLoaded !== 1'b0 || rowAddr !== '0) begin
                    reportProtocol("frameLoaded or rowAddr not cleared by reset");
                end
            end

            // frameLoaded follows the last write by a cycle, frameStart drops it at once
            if (frameLoaded !== (full && fullPrev)) begin
                reportProtocol($sformatf("frameLoaded is %b, expected %b",
                                         frameLoaded, full && fullPrev));
            end
            fullPrev = full;

            // loader rule
            if (frameStart) begin
                nextAddr = 0;
                full = 1'b0;
            end
            if (byteValid && !full) begin
                model[nextAddr] = byteData;
                if (nextAddr == frameBytes - 1) begin
                    full = 1'b1;
                end
                nextAddr++;
            end

            if (scanIdle && (panelClk || latch)) begin
                reportProtocol("panelClk or latch active while scanning is off");
            end

            // colour bits are stable over the slot, take them at the clock rise
            if (panelClk && !clkPrev) begin
                if (pulseCnt < panelWidth) begin
                    cols[pulseCnt] = {r1, g1, b1, r2, g2, b2};
                end
                pulseCnt++;
            end
            clkPrev = panelClk;

            if (latch) begin
                expRow = shownRow + 1'b1;
                if (pulseCnt != panelWidth) begin
                    reportProtocol($sformatf("%0d panelClk pulses before latch", pulseCnt));
                end
                if (rowAddr !== expRow) begin
                    reportProtocol($sformatf("rowAddr %0d at latch, expected %0d",
                                             rowAddr, expRow));
                end
                if (oeN !== 1'b1) begin
                    reportProtocol("panel not blanked during latch");
                end
                shownRow = rowAddr;
                if (checkOn) begin
                    compareRow(int'(rowAddr));
                end
                pulseCnt = 0;
            end
        end
        rstQ = rstN;
    end

endmodule

/* tb/tbClock.sv */
module tbClock (
    output logic ClockB,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    localparam int halfPeriod = 4;
    localparam int resetCycles = 3;

    initial begin
        ClockB = 1'b0;
        forever #halfPeriod ClockB = ~ClockB;
    end

    // low across three rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge ClockB);
        @(negedge ClockB);
        rstN = 1'b1;
    end

endmodule

/* hdl/ledPanelTop.sv */
module ledPanelTop (
    input  logic                         ClockB,
    input  logic                         rstN,
    input  logic                         frameStart,
    input  logic                         byteValid,
    input  panelPkg::laneWordT           byteData,
    input  logic                         scanEn,
    output logic                         frameLoaded,
    output logic                         r1,
    output logic                         g1,
    output logic                         b1,
    output logic                         r2,
    output logic                         g2,
    output logic                         b2,
    output logic                         panelClk,
    output logic                         latch,
    output logic                         oeN,
    output logic [panelPkg::rowBits-1:0] rowAddr
);
    import panelPkg::*;

    // loader to memory
    logic     wrEn;
    byteAddrT wrAddr;
    laneWordT wrData;

    // scan controller to memory and back
    laneAddrT rdAddr;
    logic     pubEn;
    pairWordT pairWord;

    // host byte stream into byte writes
    frameLoader uLoader (
        .ClockB      (ClockB),
        .rstN        (rstN),
        .frameStart  (frameStart),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .frameLoaded (frameLoaded)
    );

    // four byte lanes, read as one word per column
    multiLaneMem uMem (
        .ClockB   (ClockB),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdAddr   (rdAddr),
        .pubEn    (pubEn),
        .pairWord (pairWord)
    );

    // panel side
    scanController uScan (
        .ClockB   (ClockB),
        .rstN     (rstN),
        .scanEn   (scanEn),
        .pairWord (pairWord),
        .rdAddr   (rdAddr),
        .pubEn    (pubEn),
        .r1       (r1),
        .g1       (g1),
        .b1       (b1),
        .r2       (r2),
        .g2       (g2),
        .b2       (b2),
        .panelClk (panelClk),
        .latch    (latch),
        .oeN      (oeN),
        .rowAddr  (rowAddr)
    );

endmodule

/* hdl/scanController.sv */
module scanController (
    input  logic                        ClockB,
    input  logic                        rstN,
    input  logic                        scanEn,
    input  panelPkg::pairWordT          pairWord,
    output panelPkg::laneAddrT          rdAddr,
    output logic                        pubEn,
    output logic                        r1,
    output logic                        g1,
    output logic                        b1,
    output logic                        r2,
    output logic                        g2,
    output logic                        b2,
    output logic                        panelClk,
    output logic                        latch,
    output logic                        oeN,
    output logic [panelPkg::rowBits-1:0] rowAddr
);
    import panelPkg::*;

    typedef enum logic [1:0] {
        sIdle,
        sShift,
        sBlank,
        sLatch
    } scanStateT;

    scanStateT state;
    // cycle inside a pixel slot, also times the blank
    logic [phaseBits-1:0] phase;
    // slot count, one extra slot at the end drains the last column
    logic [colBits:0] colCnt;
    // row being shifted in, shown after the next latch
    logic [rowBits-1:0] nextRow;
    logic slotEnd;
    logic lastSlot;
    logic dataSlot;

    assign nextRow = rowAddr + 1'b1;
    assign slotEnd = (phase == phaseBits'(slotCycles - 1));
    assign lastSlot = (colCnt == (colBits + 1)'(panelWidth));
    // slot 0 only issues a read, nothing to clock out yet
    assign dataSlot = (colCnt != '0);

    // column c is addressed during all of slot c
    assign rdAddr = {nextRow, colCnt[colBits-1:0]};

    // 3 cycles after the address, data reaches the lane stage
    assign pubEn = (state == sShift) && (phase == phaseBits'(pubPhase)) && !lastSlot;

    // pairWord only changes on a slot boundary, so data is stable across the slot
    assign r1 = pairWord[laneTopHigh][redBit];
    assign g1 = pairWord[laneTopHigh][greenBit];
    assign b1 = pairWord[laneTopLow][blueBit];
    assign r2 = pairWord[laneBotHigh][redBit];
    assign g2 = pairWord[laneBotHigh][greenBit];
    assign b2 = pairWord[laneBotLow][blueBit];

    // high in the last two cycles of a slot carrying data
    assign panelClk = (state == sShift) && dataSlot && (phase >= phaseBits'(clkHighPhase));
    assign latch = (state == sLatch);
    // panel is lit only while a row shifts in
    assign oeN = (state != sShift);

    always_ff @(posedge ClockB) begin
        if (!rstN) begin
            state <= sIdle;
            phase <= '0;
            colCnt <= '0;
            rowAddr <= '0;
        end else begin
            case (state)
                sIdle: begin
                    // wait here at a row boundary until scanning is enabled
                    if (scanEn) begin
                        state <= sShift;
                        phase <= '0;
                        colCnt <= '0;
                    end
                end
                sShift: begin
                    // phase wraps by itself at the end of the slot
                    phase <= phase + 1'b1;
                    if (slotEnd) begin
                        if (lastSlot) begin
                            state <= sBlank;
                            phase <= '0;
                        end else begin
                            colCnt <= colCnt + 1'b1;
                        end
                    end
                end
                sBlank: begin
                    phase <= phase + 1'b1;
                    if (phase == phaseBits'(blankCycles - 1)) begin
                        state <= sLatch;
                        phase <= '0;
                        // new row shows up together with latch
                        rowAddr <= nextRow;
                    end
                end
                sLatch: begin
                    phase <= '0;
                    colCnt <= '0;
                    // scanEn is sampled only between rows
                    state <= scanEn ? sShift : sIdle;
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

endmodule

/* hdl/frameLoader.sv */
module frameLoader (
    input  logic               ClockB,
    input  logic               rstN,
    input  logic               frameStart,
    input  logic               byteValid,
    input  panelPkg::laneWordT byteData,
    output logic               wrEn,
    output panelPkg::byteAddrT wrAddr,
    output panelPkg::laneWordT wrData,
    output logic               frameLoaded
);
    import panelPkg::*;

    // address the next accepted byte goes to
    byteAddrT nextAddr;
    // address used this cycle, forced to 0 by frameStart
    byteAddrT baseAddr;
    // set once the last byte of the frame has been accepted
    logic     full;
    logic     accept;

    assign baseAddr = frameStart ? '0 : nextAddr;
    // a frameStart reopens the frame even when it was full
    assign accept = byteValid && (frameStart || !full);

    always_ff @(posedge ClockB) begin
        if (!rstN) begin
            nextAddr <= '0;
            full <= 1'b0;
            wrEn <= 1'b0;
            frameLoaded <= 1'b0;
        end else begin
            wrEn <= accept;
            // one cycle behind full, so it follows the last write
            frameLoaded <= full && !frameStart;
            if (frameStart) begin
                nextAddr <= '0;
                full <= 1'b0;
            end
            if (accept) begin
                nextAddr <= baseAddr + 1'b1;
                full <= (baseAddr == byteAddrT'(frameBytes - 1));
            end
        end
    end

    // write payload, raster order equals byte address order
    always_ff @(posedge ClockB) begin
        if (accept) begin
            wrAddr <= baseAddr;
            wrData <= byteData;
        end
    end

endmodule

/* hdl/multiLaneMem.sv */
module multiLaneMem (
    input  logic               ClockB,
    input  logic               rstN,
    input  logic               wrEn,
    input  panelPkg::byteAddrT wrAddr,
    input  panelPkg::laneWordT wrData,
    input  panelPkg::laneAddrT rdAddr,
    input  logic               pubEn,
    output panelPkg::pairWordT pairWord
);
    import panelPkg::*;

    // lane picked by the write: {panel half, byte of pixel}
    logic [structureBits-1:0] wrLane;
    // address inside a lane: {row of half, column}
    laneAddrT wrLaneAddr;
    // read address, registered once for all lanes
    laneAddrT rdAddrQ;
    // all lane stages side by side, lane 0 in the low byte
    logic [pairWordBits-1:0] stageBits;

    assign wrLane = {wrAddr[byteAddrBits-1 -: subpanelBits],
                     wrAddr[colorSelectBits-1:0]};
    assign wrLaneAddr = wrAddr[byteAddrBits-subpanelBits-1 -: laneAddrBits];

    // edge 1 of the read path
    always_ff @(posedge ClockB) begin
        rdAddrQ <= rdAddr;
    end

    for (genvar i = 0; i < lanes; i++) begin : gLane
        // write triplet kept next to its lane
        logic     weQ;
        laneAddrT addrQ;
        laneWordT dataQ;
        // ram output and the local stage after it
        laneWordT laneOut;
        laneWordT stageQ;

        always_ff @(posedge ClockB) begin
            if (!rstN) begin
                weQ <= 1'b0;
            end else begin
                weQ <= wrEn && (wrLane == structureBits'(i));
            end
        end

        // address and data only matter when weQ is set
        always_ff @(posedge ClockB) begin
            addrQ <= wrLaneAddr;
            dataQ <= wrData;
        end

        // ram output register is edge 2
        memLane uLane (
            .ClockB (ClockB),
            .wrEn   (weQ),
            .wrAddr (addrQ),
            .wrData (dataQ),
            .rdAddr (rdAddrQ),
            .rdData (laneOut)
        );

        // edge 3, free running
        always_ff @(posedge ClockB) begin
            stageQ <= laneOut;
        end

        assign stageBits[i*laneWordBits +: laneWordBits] = stageQ;
    end

    // edge 4, publish only when the scan asks for it
    always_ff @(posedge ClockB) begin
        if (!rstN) begin
            pairWord <= '0;
        end else if (pubEn) begin
            pairWord <= pairWordT'(stageBits);
        end
    end

endmodule

/* hdl/memLane.sv */
module memLane (
    input  logic               ClockB,
    input  logic               wrEn,
    input  panelPkg::laneAddrT wrAddr,
    input  panelPkg::laneWordT wrData,
    input  panelPkg::laneAddrT rdAddr,
    output panelPkg::laneWordT rdData
);
    import panelPkg::*;

    // one byte per half-panel pixel slot
    laneWordT ram [laneDepth];

    // simple dual port, write side
    always_ff @(posedge ClockB) begin
        if (wrEn) begin
            ram[wrAddr] <= wrData;
        end
    end

    // registered read
    // a read that collides with a write returns the old byte
    always_ff @(posedge ClockB) begin
        rdData <= ram[rdAddr];
    end

endmodule

/* hdl/panelPkg.sv */
package panelPkg;

    // panel geometry
    localparam int panelWidth = 64;
    localparam int panelHeight = 32;
    localparam int halfHeight = 16;
    localparam int bytesPerPixel = 2;
    localparam int frameBytes = panelWidth * panelHeight * bytesPerPixel;

    // byte address fields, top to bottom: subpanel, row of half, column, colour select
    localparam int colorSelectBits = $clog2(bytesPerPixel);
    localparam int subpanelBits = $clog2(panelHeight / halfHeight);
    localparam int rowBits = $clog2(halfHeight);
    localparam int colBits = $clog2(panelWidth);
    localparam int laneAddrBits = rowBits + colBits;
    localparam int byteAddrBits = subpanelBits + laneAddrBits + colorSelectBits;

    // one lane per (panel half, byte of pixel)
    localparam int structureBits = subpanelBits + colorSelectBits;
    localparam int lanes = 1 << structureBits;
    localparam int laneDepth = 1 << laneAddrBits;
    localparam int laneWordBits = 8;
    localparam int pairWordBits = lanes * laneWordBits;

    // lane index is {subpanel, colour select}
    localparam int laneTopHigh = 0;
    localparam int laneTopLow = 1;
    localparam int laneBotHigh = 2;
    localparam int laneBotLow = 3;

    // RGB565 msb positions, high byte RRRRRGGG and low byte GGGBBBBB
    localparam int redBit = 7;
    localparam int greenBit = 2;
    localparam int blueBit = 4;

    // scan timing in ClockB cycles
    localparam int slotCycles = 4;
    localparam int phaseBits = $clog2(slotCycles);
    localparam int clkHighPhase = 2;
    localparam int pubPhase = 3;
    localparam int blankCycles = 2;

    typedef logic [byteAddrBits-1:0] byteAddrT;
    typedef logic [laneAddrBits-1:0] laneAddrT;
    typedef logic [laneWordBits-1:0] laneWordT;
    // lane 3 in the top byte down to lane 0 in the bottom byte
    typedef logic [lanes-1:0][laneWordBits-1:0] pairWordT;

endpackage
